/* rtl/lcd_defs.svh */
`ifndef LCD_DEFS_SVH
`define LCD_DEFS_SVH

// ======================================================================
// Display geometry
// ======================================================================
// Characters per line on the 16x2 module
`define LCD_COLS 16
// Eight bits per character
`define LCD_LINE_BITS 128

// Brew progress arrives as 0..100
`define PCT_FULL 100

// ======================================================================
// Glyph codes, plain ASCII
// ======================================================================
`define GLYPH_SPACE 8'h20
`define GLYPH_FILL  8'h23
`define GLYPH_EMPTY 8'h2D
`define GLYPH_ZERO  8'h30

`endif

/* rtl/lcd_pkg.sv */
`default_nettype none

`include "lcd_defs.svh"

package lcd_pkg;

    // One ASCII character cell
    typedef logic [7:0] lcd_char_t;

    // Full line, leftmost cell in the top byte
    typedef logic [`LCD_LINE_BITS-1:0] lcd_line_t;

    // ======================================================================
    // Glyphs
    // ======================================================================
    // Padding and blank lines
    localparam lcd_char_t CHAR_SPACE = `GLYPH_SPACE;

    // Progress bar cells
    localparam lcd_char_t CHAR_FILL  = `GLYPH_FILL;
    localparam lcd_char_t CHAR_EMPTY = `GLYPH_EMPTY;

    // Base for decimal digits
    localparam lcd_char_t CHAR_ZERO  = `GLYPH_ZERO;

endpackage

`default_nettype wire

/* rtl/line_buffer.sv */
`default_nettype none
`timescale 1ns/10ps

`include "lcd_defs.svh"

module line_buffer (
    input  logic               clk,
    input  logic               rst_n,
    input  lcd_pkg::lcd_line_t text1_next,
    input  lcd_pkg::lcd_line_t text2_next,
    output lcd_pkg::lcd_line_t line1_text,
    output lcd_pkg::lcd_line_t line2_text,
    output logic               message_updated
);

    // Either line about to change this edge
    logic text_changed;

    assign text_changed = (text1_next != line1_text) || (text2_next != line2_text);

    // ======================================================================
    // Display registers
    // ======================================================================
    // Blank screen out of reset
    // Pulse lands on the same edge as the new text
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            line1_text      <= {`LCD_COLS{lcd_pkg::CHAR_SPACE}};
            line2_text      <= {`LCD_COLS{lcd_pkg::CHAR_SPACE}};
            message_updated <= 1'b0;
        end else begin
            line1_text      <= text1_next;
            line2_text      <= text2_next;
            // Held text repeats, so the pulse drops after one cycle
            message_updated <= text_changed;
        end
    end

endmodule

`default_nettype wire

/* rtl/menu_pkg.sv */
`default_nettype none

package menu_pkg;

    // Menu FSM state codes, numbered as in the navigator
    typedef enum logic [3:0] {
        SPLASH        = 4'd0,
        CHECK_ERRORS  = 4'd1,
        COFFEE_SELECT = 4'd2,
        DRINK_SELECT  = 4'd3,
        SIZE_SELECT   = 4'd4,
        CONFIRM       = 4'd5,
        BREWING       = 4'd6,
        COMPLETE      = 4'd7,
        SETTINGS      = 4'd8,
        ERROR         = 4'd9
    } menu_state_e;

    // Drink recipes
    typedef enum logic [2:0] {
        BLACK     = 3'd0,
        CREAM     = 3'd1,
        LATTE     = 3'd2,
        MOCHA     = 3'd3,
        HOT_CHOCO = 3'd4
    } drink_e;

    // Cup sizes, code 3 unused
    typedef enum logic [1:0] {
        OZ8  = 2'd0,
        OZ12 = 2'd1,
        OZ16 = 2'd2
    } size_e;

endpackage

`default_nettype wire

/* rtl/message_manager.sv */
`default_nettype none
`timescale 1ns/10ps

module message_manager (
    input  logic                  clk,
    input  logic                  rst_n,
    input  menu_pkg::menu_state_e menu_state,
    input  logic                  coffee_bin,
    input  menu_pkg::drink_e      drink,
    input  menu_pkg::size_e       cup_size,
    input  logic [7:0]            brew_progress,
    input  logic [3:0]            warning_count,
    input  logic                  bin0_empty,
    input  logic                  bin0_low,
    input  logic                  bin1_empty,
    input  logic                  bin1_low,
    input  logic                  paper_empty,
    input  logic                  temp_ready,
    input  logic                  pressure_ready,
    output lcd_pkg::lcd_line_t    line1_text,
    output lcd_pkg::lcd_line_t    line2_text,
    output logic                  message_updated
);

    // Composed text, not yet registered
    lcd_pkg::lcd_line_t text1_next;
    lcd_pkg::lcd_line_t text2_next;

    // ======================================================================
    // Screen text from menu state and machine status
    // ======================================================================
    screen_composer screen_composer_i (
        .menu_state     (menu_state),
        .coffee_bin     (coffee_bin),
        .drink          (drink),
        .cup_size       (cup_size),
        .brew_progress  (brew_progress),
        .warning_count  (warning_count),
        .bin0_empty     (bin0_empty),
        .bin0_low       (bin0_low),
        .bin1_empty     (bin1_empty),
        .bin1_low       (bin1_low),
        .paper_empty    (paper_empty),
        .temp_ready     (temp_ready),
        .pressure_ready (pressure_ready),
        .text1_next     (text1_next),
        .text2_next     (text2_next)
    );

    // One cycle register plus change pulse
    line_buffer line_buffer_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .text1_next      (text1_next),
        .text2_next      (text2_next),
        .line1_text      (line1_text),
        .line2_text      (line2_text),
        .message_updated (message_updated)
    );

endmodule

`default_nettype wire

/* rtl/progress_bar.sv */
`default_nettype none
`timescale 1ns/10ps

`include "lcd_defs.svh"

module progress_bar (
    input  logic [7:0]         brew_progress,
    output lcd_pkg::lcd_line_t bar_text
);

    // Worst case 255 * 16 needs 12 bits
    logic [11:0] scaled;
    // Up to 40 before the clamp
    logic [5:0]  filled_raw;
    // 0..16 filled cells
    logic [4:0]  filled;

    assign scaled     = 12'(brew_progress) * 12'(`LCD_COLS);
    // Remainder dropped, so a cell fills only when fully earned
    assign filled_raw = 6'(scaled / 12'(`PCT_FULL));

    // Inputs above 100% saturate to a full bar
    assign filled = (filled_raw > 6'(`LCD_COLS)) ? 5'(`LCD_COLS) : filled_raw[4:0];

    // Fill from the left edge
    always_comb begin
        for (int i = 0; i < `LCD_COLS; i++) begin
            if (i < int'(filled)) begin
                bar_text[(`LCD_COLS-1-i)*8 +: 8] = lcd_pkg::CHAR_FILL;
            end else begin
                bar_text[(`LCD_COLS-1-i)*8 +: 8] = lcd_pkg::CHAR_EMPTY;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/screen_composer.sv */
`default_nettype none
`timescale 1ns/10ps

`include "lcd_defs.svh"

module screen_composer (
    input  menu_pkg::menu_state_e menu_state,
    input  logic                coffee_bin,
    input  menu_pkg::drink_e    drink,
    input  menu_pkg::size_e     cup_size,
    input  logic [7:0]          brew_progress,
    input  logic [3:0]          warning_count,
    input  logic                bin0_empty,
    input  logic                bin0_low,
    input  logic                bin1_empty,
    input  logic                bin1_low,
    input  logic                paper_empty,
    input  logic                temp_ready,
    input  logic                pressure_ready,
    output lcd_pkg::lcd_line_t  text1_next,
    output lcd_pkg::lcd_line_t  text2_next
);

    // Hint shared by the three select screens
    localparam lcd_pkg::lcd_line_t SELECT_HINT = "<-> Select      ";
    // Nothing shown
    localparam lcd_pkg::lcd_line_t BLANK_LINE  = {`LCD_COLS{lcd_pkg::CHAR_SPACE}};

    // Bar for the brewing screen
    lcd_pkg::lcd_line_t bar_text;

    // Flags of the bin under the cursor
    logic sel_empty;
    logic sel_low;

    // Warning count as one ASCII cell
    lcd_pkg::lcd_char_t warn_digit;

    // ======================================================================
    // Helpers
    // ======================================================================
    progress_bar progress_bar_i (
        .brew_progress (brew_progress),
        .bar_text      (bar_text)
    );

    // coffee_bin 0 is bin 1 on screen
    assign sel_empty = coffee_bin ? bin1_empty : bin0_empty;
    assign sel_low   = coffee_bin ? bin1_low   : bin0_low;

    // One cell only, two-digit counts show blank
    assign warn_digit = (warning_count > 4'd9) ? lcd_pkg::CHAR_SPACE
                      : lcd_pkg::CHAR_ZERO + lcd_pkg::lcd_char_t'(warning_count);

    // ======================================================================
    // Screen text
    // ======================================================================
    always_comb begin
        text1_next = BLANK_LINE;
        text2_next = BLANK_LINE;
        case (menu_state)
            menu_pkg::SPLASH: begin
                text1_next = "Press Start     ";
                if (warning_count != 4'd0) begin
                    text2_next = {"Warnings: ", warn_digit, "     "};
                end else begin
                    text2_next = "Ready           ";
                end
            end
            menu_pkg::CHECK_ERRORS: begin
                text1_next = "Checking...     ";
                text2_next = "Please wait     ";
            end
            menu_pkg::COFFEE_SELECT: begin
                text1_next = coffee_bin ? "Coffee: [2]     " : "Coffee: [1]     ";
                // Empty wins over low
                if (sel_empty) begin
                    text2_next = "Empty!          ";
                end else if (sel_low) begin
                    text2_next = "Low             ";
                end else begin
                    text2_next = SELECT_HINT;
                end
            end
            menu_pkg::DRINK_SELECT: begin
                case (drink)
                    menu_pkg::BLACK:     text1_next = "Drink: [Black]  ";
                    menu_pkg::CREAM:     text1_next = "Drink: [Cream]  ";
                    menu_pkg::LATTE:     text1_next = "Drink: [Latte]  ";
                    menu_pkg::MOCHA:     text1_next = "Drink: [Mocha]  ";
                    // Name cut at the right edge
                    menu_pkg::HOT_CHOCO: text1_next = "Drink: [HotChoco";
                    default:             text1_next = "Drink: ?        ";
                endcase
                text2_next = SELECT_HINT;
            end
            menu_pkg::SIZE_SELECT: begin
                case (cup_size)
                    menu_pkg::OZ8:  text1_next = "Size: [8oz]     ";
                    menu_pkg::OZ12: text1_next = "Size: [12oz]    ";
                    menu_pkg::OZ16: text1_next = "Size: [16oz]    ";
                    default:        text1_next = "Size: ?         ";
                endcase
                text2_next = SELECT_HINT;
            end
            menu_pkg::BREWING: begin
                text1_next = "Brewing...      ";
                text2_next = bar_text;
            end
            menu_pkg::COMPLETE: begin
                text1_next = "Enjoy!          ";
                text2_next = "Press any key   ";
            end
            menu_pkg::ERROR: begin
                // Water faults first, then consumables
                if (!temp_ready) begin
                    text1_next = "WATER TEMP!     ";
                end else if (!pressure_ready) begin
                    text1_next = "WATER ERROR!    ";
                end else if (paper_empty) begin
                    text1_next = "NO PAPER!       ";
                end else if (bin0_empty && bin1_empty) begin
                    text1_next = "NO COFFEE!      ";
                end else begin
                    text1_next = "SYSTEM FAULT!   ";
                end
                text2_next = "Fix & restart   ";
            end
            // Confirm, settings and unused codes
            default: begin
                text1_next = "ERROR           ";
                text2_next = BLANK_LINE;
            end
        endcase
    end

endmodule

`default_nettype wire

/* tests/message_golden.txt */
// Columns: inputs, expected line1_text, expected line2_text, expected message_updated
// Inputs nibbles: state, coffee_bin, drink, cup_size, progress (2), warnings, status (2)
// Status bits 6..0: bin0_empty bin0_low bin1_empty bin1_low paper_empty temp_ready pressure_ready
000000303 50726573732053746172742020202020 5761726E696E67733A20332020202020 1 // splash, 3 warnings
000000C03 50726573732053746172742020202020 5761726E696E67733A20202020202020 1 // splash, 12 warnings
000000903 50726573732053746172742020202020 5761726E696E67733A20392020202020 1 // splash, 9 warnings
000000003 50726573732053746172742020202020 52656164792020202020202020202020 1 // splash, ready
002000003 50726573732053746172742020202020 52656164792020202020202020202020 0 // same text
100000003 436865636B696E672E2E2E2020202020 506C6561736520776169742020202020 1 // checking
200000003 436F666665653A205B315D2020202020 3C2D3E2053656C656374202020202020 1 // bin 1 ok
200000023 436F666665653A205B315D2020202020 4C6F7720202020202020202020202020 1 // bin 1 low
200000063 436F666665653A205B315D2020202020 456D7074792120202020202020202020 1 // bin 1 empty
21000004B 436F666665653A205B325D2020202020 4C6F7720202020202020202020202020 1 // bin 2 low
21000001B 436F666665653A205B325D2020202020 456D7074792120202020202020202020 1 // bin 2 empty
210000003 436F666665653A205B325D2020202020 3C2D3E2053656C656374202020202020 1 // bin 2 ok
300000003 4472696E6B3A205B426C61636B5D2020 3C2D3E2053656C656374202020202020 1 // black
301000003 4472696E6B3A205B437265616D5D2020 3C2D3E2053656C656374202020202020 1 // cream
302000003 4472696E6B3A205B4C617474655D2020 3C2D3E2053656C656374202020202020 1 // latte
303000003 4472696E6B3A205B4D6F6368615D2020 3C2D3E2053656C656374202020202020 1 // mocha
304000003 4472696E6B3A205B486F7443686F636F 3C2D3E2053656C656374202020202020 1 // hot choco
305000003 4472696E6B3A203F2020202020202020 3C2D3E2053656C656374202020202020 1 // unknown drink
400000003 53697A653A205B386F7A5D2020202020 3C2D3E2053656C656374202020202020 1 // 8 oz
400100003 53697A653A205B31326F7A5D20202020 3C2D3E2053656C656374202020202020 1 // 12 oz
400200003 53697A653A205B31366F7A5D20202020 3C2D3E2053656C656374202020202020 1 // 16 oz
400300003 53697A653A203F202020202020202020 3C2D3E2053656C656374202020202020 1 // unknown size
600000003 42726577696E672E2E2E202020202020 2D2D2D2D2D2D2D2D2D2D2D2D2D2D2D2D 1 // 0 percent
600006003 42726577696E672E2E2E202020202020 2D2D2D2D2D2D2D2D2D2D2D2D2D2D2D2D 0 // 6 percent
600007003 42726577696E672E2E2E202020202020 232D2D2D2D2D2D2D2D2D2D2D2D2D2D2D 1 // 7 percent
600032003 42726577696E672E2E2E202020202020 23232323232323232D2D2D2D2D2D2D2D 1 // 50 percent
600064003 42726577696E672E2E2E202020202020 23232323232323232323232323232323 1 // 100 percent
6000C8003 42726577696E672E2E2E202020202020 23232323232323232323232323232323 0 // 200 percent
600001003 42726577696E672E2E2E202020202020 2D2D2D2D2D2D2D2D2D2D2D2D2D2D2D2D 1 // 1 percent
600002003 42726577696E672E2E2E202020202020 2D2D2D2D2D2D2D2D2D2D2D2D2D2D2D2D 0 // 2 percent
700000003 456E6A6F792120202020202020202020 507265737320616E79206B6579202020 1 // complete
900000004 57415445522054454D50212020202020 46697820262072657374617274202020 1 // temp first
900000006 5741544552204552524F522120202020 46697820262072657374617274202020 1 // pressure next
900000057 4E4F2050415045522120202020202020 46697820262072657374617274202020 1 // paper next
900000053 4E4F20434F4646454521202020202020 46697820262072657374617274202020 1 // both bins
900000043 53595354454D204641554C5421202020 46697820262072657374617274202020 1 // one bin only
800000003 4552524F522020202020202020202020 20202020202020202020202020202020 1 // settings
500000003 4552524F522020202020202020202020 20202020202020202020202020202020 0 // confirm
F00000003 4552524F522020202020202020202020 20202020202020202020202020202020 0 // code 15
000000003 50726573732053746172742020202020 52656164792020202020202020202020 1 // splash again

/* tests/message_manager_props.sv */
`default_nettype none
`timescale 1ns/10ps

module message_manager_props (
    input logic               clk,
    input logic               rst_n,
    input lcd_pkg::lcd_line_t line1_text,
    input lcd_pkg::lcd_line_t line2_text,
    input logic               message_updated
);

    // Reset value still visible on the first active edge
    property quiet_after_reset;
        @(posedge clk) $rose(rst_n) |-> !message_updated;
    endproperty

    // A pulse always comes with new text
    property pulse_has_change;
        @(posedge clk) disable iff (!rst_n)
            message_updated |->
                (line1_text != $past(line1_text)) || (line2_text != $past(line2_text));
    endproperty

    // New text on either line, pulse alongside
    property change_has_pulse;
        @(posedge clk) disable iff (!rst_n)
            ((line1_text != $past(line1_text)) || (line2_text != $past(line2_text)))
                |-> message_updated;
    endproperty

    quiet_after_reset_a: assert property (quiet_after_reset)
        else $error("message_updated high in the first cycle after reset");
    pulse_has_change_a: assert property (pulse_has_change)
        else $error("message_updated high while neither line changed");
    change_has_pulse_a: assert property (change_has_pulse)
        else $error("a line changed while message_updated stayed low");

endmodule

bind line_buffer message_manager_props message_manager_props_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .line1_text      (line1_text),
    .line2_text      (line2_text),
    .message_updated (message_updated)
);

`default_nettype wire

/* tests/tb_message_manager.sv */
`default_nettype none
`timescale 1ns/10ps

`include "lcd_defs.svh"

module tb_message_manager;

    localparam int NUM_VECTORS   = 40;
    localparam int WORDS_PER_VEC = 4;
    localparam int RESET_CYCLES  = 16;
    // Reset, two cycles per vector, then slack
    localparam int CYCLE_LIMIT   = RESET_CYCLES + 2 * NUM_VECTORS + 50;

    localparam lcd_pkg::lcd_line_t BLANK_LINE = {`LCD_COLS{lcd_pkg::CHAR_SPACE}};

    logic                  clk;
    logic                  rst_n;
    menu_pkg::menu_state_e menu_state;
    logic                  coffee_bin;
    menu_pkg::drink_e      drink;
    menu_pkg::size_e       cup_size;
    logic [7:0]            brew_progress;
    logic [3:0]            warning_count;
    logic                  bin0_empty;
    logic                  bin0_low;
    logic                  bin1_empty;
    logic                  bin1_low;
    logic                  paper_empty;
    logic                  temp_ready;
    logic                  pressure_ready;
    lcd_pkg::lcd_line_t    line1_text;
    lcd_pkg::lcd_line_t    line2_text;
    logic                  message_updated;

    // Four words per vector: inputs, line1, line2, flag
    logic [127:0] golden_mem [0:NUM_VECTORS*WORDS_PER_VEC-1];

    int test_count;
    int fail_count;
    int cycle_count;

    // Text expected on the display before the current vector
    lcd_pkg::lcd_line_t prev_line1;
    lcd_pkg::lcd_line_t prev_line2;

    message_manager message_manager_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .menu_state      (menu_state),
        .coffee_bin      (coffee_bin),
        .drink           (drink),
        .cup_size        (cup_size),
        .brew_progress   (brew_progress),
        .warning_count   (warning_count),
        .bin0_empty      (bin0_empty),
        .bin0_low        (bin0_low),
        .bin1_empty      (bin1_empty),
        .bin1_low        (bin1_low),
        .paper_empty     (paper_empty),
        .temp_ready      (temp_ready),
        .pressure_ready  (pressure_ready),
        .line1_text      (line1_text),
        .line2_text      (line2_text),
        .message_updated (message_updated)
    );

    // ======================================================================
    // Clock and watchdog
    // ======================================================================
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Run stopped after %0d cycles without reaching the end", CYCLE_LIMIT);
        $display("Some tests failed");
        $finish;
    end

    // Unpack one nibble-aligned input word onto the DUT pins
    task automatic drive_inputs(input logic [35:0] word);
        menu_state     = menu_pkg::menu_state_e'(word[35:32]);
        coffee_bin     = word[28];
        drink          = menu_pkg::drink_e'(word[26:24]);
        cup_size       = menu_pkg::size_e'(word[21:20]);
        brew_progress  = word[19:12];
        warning_count  = word[11:8];
        bin0_empty     = word[6];
        bin0_low       = word[5];
        bin1_empty     = word[4];
        bin1_low       = word[3];
        paper_empty    = word[2];
        temp_ready     = word[1];
        pressure_ready = word[0];
    endtask

    task automatic finish_test(input int idx, input int errs);
        test_count++;
        if (errs == 0) begin
            $display("test %0d ok", idx);
        end else begin
            fail_count++;
            $display("test %0d failed with %0d mismatches", idx, errs);
        end
    endtask

    // Called 1 ns after an edge; leaves at the same point two edges later
    task automatic run_vector(input int vec);
        int                 base;
        int                 errs;
        lcd_pkg::lcd_line_t exp1;
        lcd_pkg::lcd_line_t exp2;
        logic               exp_flag;
        logic               own_flag;
        base     = vec * WORDS_PER_VEC;
        errs     = 0;
        exp1     = golden_mem[base+1];
        exp2     = golden_mem[base+2];
        exp_flag = golden_mem[base+3][0];
        // Pulse only where the text moves
        own_flag = (exp1 != prev_line1) || (exp2 != prev_line2);
        if (own_flag !== exp_flag) begin
            $display("Golden flag of vector %0d disagrees with its text change", vec);
            errs++;
        end
        drive_inputs(golden_mem[base][35:0]);
        @(posedge clk);
        #1;
        if (line1_text !== exp1) begin
            $display("FAIL vector %0d line1_text expected %h actual %h", vec, exp1, line1_text);
            errs++;
        end
        if (line2_text !== exp2) begin
            $display("FAIL vector %0d line2_text expected %h actual %h", vec, exp2, line2_text);
            errs++;
        end
        if (message_updated !== own_flag) begin
            $display("FAIL vector %0d message_updated expected %h actual %h",
                     vec, own_flag, message_updated);
            errs++;
        end
        // Second cycle, same text, pulse gone
        @(posedge clk);
        #1;
        if (message_updated !== 1'b0) begin
            $display("FAIL vector %0d message_updated expected %h actual %h",
                     vec, 1'b0, message_updated);
            errs++;
        end
        prev_line1 = exp1;
        prev_line2 = exp2;
        finish_test(vec + 1, errs);
    endtask

    // ======================================================================
    // Main sequence
    // ======================================================================
    initial begin
        int errs;
        test_count = 0;
        fail_count = 0;
        prev_line1 = BLANK_LINE;
        prev_line2 = BLANK_LINE;
        rst_n      = 1'b0;
        drive_inputs(36'h0_0_0_0_00_0_03);
        $readmemh("tests/message_golden.txt", golden_mem);

        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Blank display straight out of reset
        errs = 0;
        if (line1_text !== BLANK_LINE) begin
            $display("FAIL reset line1_text expected %h actual %h", BLANK_LINE, line1_text);
            errs++;
        end
        if (line2_text !== BLANK_LINE) begin
            $display("FAIL reset line2_text expected %h actual %h", BLANK_LINE, line2_text);
            errs++;
        end
        if (message_updated !== 1'b0) begin
            $display("FAIL reset message_updated expected %h actual %h", 1'b0, message_updated);
            errs++;
        end
        finish_test(0, errs);

        if ($isunknown(golden_mem[NUM_VECTORS*WORDS_PER_VEC-1])) begin
            $display("Golden vector file is missing or shorter than expected");
            fail_count++;
        end else begin
            for (int v = 0; v < NUM_VECTORS; v++) begin
                run_vector(v);
            end
        end

        $display("Tests run: %0d, passed: %0d, failed: %0d",
                 test_count, test_count - fail_count, fail_count);
        if (fail_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+rtl
rtl/menu_pkg.sv
rtl/lcd_pkg.sv
rtl/progress_bar.sv
rtl/screen_composer.sv
rtl/line_buffer.sv
rtl/message_manager.sv
tests/message_manager_props.sv
tests/tb_message_manager.sv
